/* source/SchedulerPkg.sv */
`default_nettype none

package SchedulerPkg;

    // Physical register number and op tag widths
    localparam int REG_NUM_BIT_WIDTH = 5;
    localparam int TAG_BIT_WIDTH = 6;

    // Source operands per micro-op
    localparam int SRC_OP_NUM = 2;

    typedef logic [REG_NUM_BIT_WIDTH-1:0] RegNumPath;
    typedef logic [TAG_BIT_WIDTH-1:0] OpTag;

    // Micro-op as it arrives in program order
    typedef struct packed {
        OpTag tag;
        logic dstValid;
        RegNumPath dstReg;
        logic [SRC_OP_NUM-1:0] srcValid;
        RegNumPath [SRC_OP_NUM-1:0] srcReg;
    } DispatchOp;

    // Micro-op waiting in the issue queue
    typedef struct packed {
        DispatchOp op;
        // Set once the producer of each source has completed
        logic [SRC_OP_NUM-1:0] srcReady;
    } QueueEntry;

    // Only the destination travels down the execution pipe
    typedef struct packed {
        OpTag tag;
        logic dstValid;
        RegNumPath dstReg;
    } ExecOp;

    // Ready bit table init sequencing
    typedef enum logic [0:0] {
        INIT_SWEEP,
        INIT_DONE
    } InitState;

    // Issue queue slot occupancy
    typedef enum logic [0:0] {
        ENTRY_FREE,
        ENTRY_WAITING
    } EntryState;

endpackage

`default_nettype wire

/* source/ReadyBitTable.sv */
`timescale 1ns/1ps
`default_nettype none

module ReadyBitTable (
    input  logic clk,
    input  logic rst,
    input  SchedulerPkg::RegNumPath [SchedulerPkg::SRC_OP_NUM-1:0] lookupReg,
    input  logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupValid,
    input  logic dispatchWe,
    input  SchedulerPkg::RegNumPath dispatchReg,
    input  logic wakeupValid,
    input  SchedulerPkg::RegNumPath wakeupReg,
    output logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupReady,
    output logic initDone
);

    localparam int REG_ENTRY_NUM = 1 << SchedulerPkg::REG_NUM_BIT_WIDTH;
    localparam SchedulerPkg::RegNumPath LAST_INDEX =
        SchedulerPkg::RegNumPath'(REG_ENTRY_NUM - 1);

    SchedulerPkg::InitState state;
    SchedulerPkg::RegNumPath sweepIndex;
    logic [REG_ENTRY_NUM-1:0] readyBits;

    assign initDone = (state == SchedulerPkg::INIT_DONE);

    // Sweep sequencer, one register per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SchedulerPkg::INIT_SWEEP;
            sweepIndex <= '0;
        end else if (state == SchedulerPkg::INIT_SWEEP) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == LAST_INDEX) begin
                state <= SchedulerPkg::INIT_DONE;
            end
        end
    end

    // Ready vector itself
    always_ff @(posedge clk) begin
        if (!rst) begin
            if (state == SchedulerPkg::INIT_SWEEP) begin
                // Only the sweep writes, stray wakeups or dispatches are dropped
                readyBits[sweepIndex] <= 1'b1;
            end else begin
                if (wakeupValid) begin
                    readyBits[wakeupReg] <= 1'b1;
                end
                // Later assignment, so the dispatch clear wins on a collision
                if (dispatchWe) begin
                    readyBits[dispatchReg] <= 1'b0;
                end
            end
        end
    end

    // Lookup with same-cycle wakeup bypass
    always_comb begin
        for (int i = 0; i < SchedulerPkg::SRC_OP_NUM; i++) begin
            if (!lookupValid[i]) begin
                // Absent source never blocks issue
                lookupReady[i] = 1'b1;
            end else if (wakeupValid && wakeupReg == lookupReg[i]) begin
                lookupReady[i] = 1'b1;
            end else begin
                lookupReady[i] = readyBits[lookupReg[i]];
            end
        end
    end

    // Dispatch must hold off until the sweep has finished
    assert property (@(posedge clk) disable iff (rst)
        state == SchedulerPkg::INIT_SWEEP |-> !dispatchWe);

endmodule

`default_nettype wire

/* source/DispatchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module DispatchStage (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  SchedulerPkg::DispatchOp inOp,
    input  logic initDone,
    input  logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupReady,
    input  logic queueFull,
    output logic inReady,
    output SchedulerPkg::RegNumPath [SchedulerPkg::SRC_OP_NUM-1:0] lookupReg,
    output logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupValid,
    output logic dispatchWe,
    output SchedulerPkg::RegNumPath dispatchReg,
    output logic writeValid,
    output SchedulerPkg::QueueEntry writeEntry
);

    logic stageValid;
    SchedulerPkg::DispatchOp stageOp;

    // Held op moves on whenever the queue has a free slot
    assign writeValid = stageValid && !queueFull;
    assign inReady = initDone && (!stageValid || writeValid);

    // Readiness is sampled from the table in the cycle of the queue write
    assign lookupReg = stageOp.srcReg;
    assign lookupValid = stageOp.srcValid;

    assign writeEntry.op = stageOp;
    assign writeEntry.srcReady = lookupReady;

    // Destination becomes pending as the op enters the queue
    assign dispatchWe = writeValid && stageOp.dstValid;
    assign dispatchReg = stageOp.dstReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else if (inReady) begin
            stageValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            stageOp <= inOp;
        end
    end

endmodule

`default_nettype wire

/* source/IssueQueue.sv */
`timescale 1ns/1ps
`default_nettype none

module IssueQueue #(
    parameter int IQ_ENTRY_NUM = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic writeValid,
    input  SchedulerPkg::QueueEntry writeEntry,
    input  logic wakeupValid,
    input  SchedulerPkg::RegNumPath wakeupReg,
    input  logic execStall,
    output logic queueFull,
    output logic issueValid,
    output SchedulerPkg::ExecOp issueOp
);

    localparam int IDX_BIT_WIDTH = (IQ_ENTRY_NUM > 1) ? $clog2(IQ_ENTRY_NUM) : 1;

    SchedulerPkg::QueueEntry entries [IQ_ENTRY_NUM];
    SchedulerPkg::EntryState entryState [IQ_ENTRY_NUM];

    logic freeFound;
    logic [IDX_BIT_WIDTH-1:0] freeIndex;
    logic selectFound;
    logic [IDX_BIT_WIDTH-1:0] selectIndex;

    // Lowest free slot takes the next write
    always_comb begin
        freeFound = 1'b0;
        freeIndex = '0;
        for (int i = 0; i < IQ_ENTRY_NUM; i++) begin
            if (!freeFound && entryState[i] == SchedulerPkg::ENTRY_FREE) begin
                freeFound = 1'b1;
                freeIndex = IDX_BIT_WIDTH'(i);
            end
        end
    end

    assign queueFull = !freeFound;

    // Oldest-slot-first is not tracked, lowest index wins
    always_comb begin
        selectFound = 1'b0;
        selectIndex = '0;
        for (int i = 0; i < IQ_ENTRY_NUM; i++) begin
            if (!selectFound && entryState[i] == SchedulerPkg::ENTRY_WAITING
                && &entries[i].srcReady) begin
                selectFound = 1'b1;
                selectIndex = IDX_BIT_WIDTH'(i);
            end
        end
    end

    assign issueValid = selectFound && !execStall;
    assign issueOp.tag = entries[selectIndex].op.tag;
    assign issueOp.dstValid = entries[selectIndex].op.dstValid;
    assign issueOp.dstReg = entries[selectIndex].op.dstReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < IQ_ENTRY_NUM; i++) begin
                entryState[i] <= SchedulerPkg::ENTRY_FREE;
            end
        end else begin
            if (issueValid) begin
                entryState[selectIndex] <= SchedulerPkg::ENTRY_FREE;
            end
            if (writeValid) begin
                entryState[freeIndex] <= SchedulerPkg::ENTRY_WAITING;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Tag match against the completion broadcast
        for (int i = 0; i < IQ_ENTRY_NUM; i++) begin
            for (int j = 0; j < SchedulerPkg::SRC_OP_NUM; j++) begin
                if (wakeupValid && entryState[i] == SchedulerPkg::ENTRY_WAITING
                    && entries[i].op.srcValid[j]
                    && entries[i].op.srcReg[j] == wakeupReg) begin
                    entries[i].srcReady[j] <= 1'b1;
                end
            end
        end
        // Incoming entry already carries the bypassed wakeup from the table
        if (writeValid) begin
            entries[freeIndex] <= writeEntry;
        end
    end

    // Dispatch has to respect the full flag
    assert property (@(posedge clk) disable iff (rst) queueFull |-> !writeValid);

endmodule

`default_nettype wire

/* source/ExecLatencyPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module ExecLatencyPipe #(
    parameter int EXEC_LATENCY = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic issueValid,
    input  SchedulerPkg::ExecOp issueOp,
    input  logic doneReady,
    output logic execStall,
    output logic doneValid,
    output SchedulerPkg::OpTag doneTag,
    output logic wakeupValid,
    output SchedulerPkg::RegNumPath wakeupReg
);

    logic [EXEC_LATENCY-1:0] slotValid;
    SchedulerPkg::ExecOp slotOp [EXEC_LATENCY];

    // Whole pipe freezes while the last slot cannot leave
    assign execStall = slotValid[EXEC_LATENCY-1] && !doneReady;

    assign doneValid = slotValid[EXEC_LATENCY-1];
    assign doneTag = slotOp[EXEC_LATENCY-1].tag;

    // Broadcast only on an actual completion transfer
    assign wakeupValid = doneValid && doneReady && slotOp[EXEC_LATENCY-1].dstValid;
    assign wakeupReg = slotOp[EXEC_LATENCY-1].dstReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
        end else if (!execStall) begin
            slotValid[0] <= issueValid;
            for (int i = 1; i < EXEC_LATENCY; i++) begin
                slotValid[i] <= slotValid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!execStall) begin
            slotOp[0] <= issueOp;
            for (int i = 1; i < EXEC_LATENCY; i++) begin
                slotOp[i] <= slotOp[i-1];
            end
        end
    end

    // An op issued into a frozen pipe would be dropped
    assert property (@(posedge clk) disable iff (rst)
        execStall |-> !issueValid);

endmodule

`default_nettype wire

/* source/SchedulerTop.sv */
`timescale 1ns/1ps
`default_nettype none

module SchedulerTop #(
    parameter int IQ_ENTRY_NUM = 4,
    parameter int EXEC_LATENCY = 3
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  SchedulerPkg::DispatchOp inOp,
    output logic inReady,
    output logic doneValid,
    output SchedulerPkg::OpTag doneTag,
    input  logic doneReady
);

    SchedulerPkg::RegNumPath [SchedulerPkg::SRC_OP_NUM-1:0] lookupReg;
    logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupValid;
    logic [SchedulerPkg::SRC_OP_NUM-1:0] lookupReady;
    logic dispatchWe;
    SchedulerPkg::RegNumPath dispatchReg;
    logic initDone;
    logic writeValid;
    SchedulerPkg::QueueEntry writeEntry;
    logic queueFull;
    logic issueValid;
    SchedulerPkg::ExecOp issueOp;
    logic execStall;
    logic wakeupValid;
    SchedulerPkg::RegNumPath wakeupReg;

    ReadyBitTable readyBitTable (
        .clk(clk),
        .rst(rst),
        .lookupReg(lookupReg),
        .lookupValid(lookupValid),
        .dispatchWe(dispatchWe),
        .dispatchReg(dispatchReg),
        .wakeupValid(wakeupValid),
        .wakeupReg(wakeupReg),
        .lookupReady(lookupReady),
        .initDone(initDone)
    );

    DispatchStage dispatchStage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inOp(inOp),
        .initDone(initDone),
        .lookupReady(lookupReady),
        .queueFull(queueFull),
        .inReady(inReady),
        .lookupReg(lookupReg),
        .lookupValid(lookupValid),
        .dispatchWe(dispatchWe),
        .dispatchReg(dispatchReg),
        .writeValid(writeValid),
        .writeEntry(writeEntry)
    );

    IssueQueue #(
        .IQ_ENTRY_NUM(IQ_ENTRY_NUM)
    ) issueQueue (
        .clk(clk),
        .rst(rst),
        .writeValid(writeValid),
        .writeEntry(writeEntry),
        .wakeupValid(wakeupValid),
        .wakeupReg(wakeupReg),
        .execStall(execStall),
        .queueFull(queueFull),
        .issueValid(issueValid),
        .issueOp(issueOp)
    );

    // Completion side also closes the wakeup loop
    ExecLatencyPipe #(
        .EXEC_LATENCY(EXEC_LATENCY)
    ) execLatencyPipe (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueOp(issueOp),
        .doneReady(doneReady),
        .execStall(execStall),
        .doneValid(doneValid),
        .doneTag(doneTag),
        .wakeupValid(wakeupValid),
        .wakeupReg(wakeupReg)
    );

endmodule

`default_nettype wire

/* sim/SchedulerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module SchedulerTb;

    localparam int EXEC_LATENCY = 3;
    localparam int ROW_NUM = 20;
    localparam int TAG_BASE = 8;
    localparam int TAG_NUM = 1 << SchedulerPkg::TAG_BIT_WIDTH;

    logic clk;
    logic rst;
    logic inValid;
    SchedulerPkg::DispatchOp inOp;
    logic inReady;
    logic doneValid;
    SchedulerPkg::OpTag doneTag;
    logic doneReady;

    // Stimulus rows and the producer row of each source, -1 when none
    SchedulerPkg::DispatchOp stimTable [ROW_NUM];
    int prodRow [ROW_NUM][SchedulerPkg::SRC_OP_NUM];
    int doneCount [TAG_NUM];
    int doneCycle [TAG_NUM];
    int cycleCount = 0;
    int completedCount = 0;
    int errorCount = 0;
    logic holdPending = 1'b0;
    SchedulerPkg::OpTag heldTag;

    SchedulerTop #(
        .IQ_ENTRY_NUM(4),
        .EXEC_LATENCY(EXEC_LATENCY)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inOp(inOp),
        .inReady(inReady),
        .doneValid(doneValid),
        .doneTag(doneTag),
        .doneReady(doneReady)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic setRow(input int row, input logic dstValid, input int dstReg,
                          input logic [1:0] srcValid, input int src1, input int src0);
        stimTable[row].tag = SchedulerPkg::OpTag'(TAG_BASE + row);
        stimTable[row].dstValid = dstValid;
        stimTable[row].dstReg = SchedulerPkg::RegNumPath'(dstReg);
        stimTable[row].srcValid = srcValid;
        stimTable[row].srcReg[1] = SchedulerPkg::RegNumPath'(src1);
        stimTable[row].srcReg[0] = SchedulerPkg::RegNumPath'(src0);
    endtask

    // Every destination register is written by one row only
    task automatic buildTable();
        setRow(0, 1'b1, 1, 2'b00, 0, 0);
        setRow(1, 1'b1, 2, 2'b01, 0, 1);
        setRow(2, 1'b1, 3, 2'b01, 0, 2);
        setRow(3, 1'b1, 4, 2'b11, 1, 3);
        // Sources name pending registers but are marked invalid
        setRow(4, 1'b0, 0, 2'b00, 4, 3);
        setRow(5, 1'b1, 5, 2'b00, 4, 4);
        // Long dependent chain that fills the queue
        for (int i = 6; i < 16; i++) begin
            setRow(i, 1'b1, i, 2'b01, 0, i - 1);
        end
        setRow(16, 1'b1, 16, 2'b01, 0, 0);
        setRow(17, 1'b0, 0, 2'b11, 15, 16);
        setRow(18, 1'b1, 17, 2'b11, 7, 11);
        setRow(19, 1'b1, 18, 2'b00, 15, 17);
    endtask

    task automatic findProducers();
        for (int i = 0; i < ROW_NUM; i++) begin
            for (int j = 0; j < SchedulerPkg::SRC_OP_NUM; j++) begin
                prodRow[i][j] = -1;
                for (int k = 0; k < i; k++) begin
                    if (stimTable[k].dstValid
                        && stimTable[k].dstReg == stimTable[i].srcReg[j]) begin
                        prodRow[i][j] = k;
                    end
                end
            end
        end
    endtask

    task automatic recordCompletion(input SchedulerPkg::OpTag tag);
        int row;
        int prodTag;
        row = int'(tag) - TAG_BASE;
        assert (row >= 0 && row < ROW_NUM) else begin
            $display("Completion arrived for tag 0x%h, which was never sent", tag);
            errorCount++;
        end
        if (row >= 0 && row < ROW_NUM) begin
            assert (doneCount[tag] == 0) else begin
                $display("** Error: doneTag 0x%h seen again, doneCount 0x%h, expected 0x0",
                         tag, doneCount[tag]);
                errorCount++;
            end
            for (int j = 0; j < SchedulerPkg::SRC_OP_NUM; j++) begin
                if (stimTable[row].srcValid[j] && prodRow[row][j] >= 0) begin
                    prodTag = prodRow[row][j] + TAG_BASE;
                    assert (doneCount[prodTag] > 0) else begin
                        $display("Op with tag 0x%h completed before its producer 0x%h",
                                 tag, prodTag);
                        errorCount++;
                    end
                    assert (doneCount[prodTag] == 0
                            || cycleCount - doneCycle[prodTag] >= EXEC_LATENCY + 1) else begin
                        $display("** Error: doneTag 0x%h gap 0x%h after 0x%h, expected >= 0x%h",
                                 tag, cycleCount - doneCycle[prodTag], prodTag,
                                 EXEC_LATENCY + 1);
                        errorCount++;
                    end
                end
            end
            doneCount[tag]++;
            doneCycle[tag] = cycleCount;
            completedCount++;
        end
    endtask

    // Completion monitor, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (holdPending) begin
                assert (doneValid && doneTag == heldTag) else begin
                    $display("** Error: doneTag 0x%h doneValid 0x%h, expected 0x%h held",
                             doneTag, doneValid, heldTag);
                    errorCount++;
                end
            end
            holdPending = doneValid && !doneReady;
            heldTag = doneTag;
            if (doneValid && doneReady) begin
                recordCompletion(doneTag);
            end
        end
    end

    // Randomized completion back-pressure
    initial begin
        logic [31:0] rngState;
        rngState = 32'h46f9_2cb0;
        doneReady = 1'b0;
        forever begin
            @(posedge clk);
            rngState = xorshift32(rngState);
            doneReady <= (rngState[1:0] != 2'b00);
        end
    end

    initial begin
        int waits;
        bit sendOk;
        rst = 1'b1;
        inValid = 1'b0;
        inOp = '0;
        for (int i = 0; i < TAG_NUM; i++) begin
            doneCount[i] = 0;
            doneCycle[i] = 0;
        end
        buildTable();
        findProducers();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Table sweep, nothing may complete before input opens
        waits = 0;
        @(negedge clk);
        while (!inReady && waits < 40) begin
            assert (!doneValid) else begin
                $display("** Error: doneValid 0x%h during reset sweep, expected 0x0", doneValid);
                errorCount++;
            end
            waits++;
            @(negedge clk);
        end

        if (!inReady) begin
            $display("Timeout: inReady did not rise within 40 cycles after reset");
            errorCount++;
        end else begin
            sendOk = 1'b1;
            for (int i = 0; i < ROW_NUM && sendOk; i++) begin
                @(posedge clk);
                inValid <= 1'b1;
                inOp <= stimTable[i];
                waits = 0;
                @(negedge clk);
                while (!inReady && waits < 200) begin
                    waits++;
                    @(negedge clk);
                end
                if (!inReady) begin
                    $display("Timeout: row %0d was not accepted within 200 cycles", i);
                    errorCount++;
                    sendOk = 1'b0;
                end
            end
            @(posedge clk);
            inValid <= 1'b0;

            waits = 0;
            while (completedCount < ROW_NUM && waits < 2000) begin
                waits++;
                @(posedge clk);
            end
            if (completedCount < ROW_NUM) begin
                $display("Timeout: only %0d of %0d ops completed", completedCount, ROW_NUM);
                errorCount++;
            end
            // Extra cycles to catch late duplicate completions
            repeat (10) @(posedge clk);
        end

        for (int i = 0; i < ROW_NUM; i++) begin
            assert (doneCount[TAG_BASE + i] == 1) else begin
                $display("** Error: doneCount 0x%h for tag 0x%h, expected 0x1",
                         doneCount[TAG_BASE + i], TAG_BASE + i);
                errorCount++;
            end
        end

        $display("Check summary: %0d errors, %0d completions", errorCount, completedCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
source/SchedulerPkg.sv
source/ReadyBitTable.sv
source/DispatchStage.sv
source/IssueQueue.sv
source/ExecLatencyPipe.sv
source/SchedulerTop.sv
sim/SchedulerTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module SchedulerTb \
    -f verilog.f -o SchedulerTb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/SchedulerTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$SIM_LOG"; then
    exit 1
fi
exit 0
